//--- all.f
hdl/csr_pkg.sv
hdl/csr_commit_buffer.sv
hdl/csr_counters.sv
hdl/csr_trap_state.sv
hdl/csr_read_port.sv
hdl/csr_unit_top.sv
tests/csr_unit_asserts.sv
tests/csr_unit_tb.sv

//--- tests/csr_unit_tb.sv
// directed testbench for the CSR unit, simulation top that drives csr_unit_top through its features
`timescale 1ns/100ps

module csr_unit_tb;
  import csr_pkg::*;

  localparam int        CLK_PERIOD  = 4;
  localparam int        TEST_COUNT  = 6;
  // every directed test finishes well inside this many cycles
  localparam int        TEST_CYCLES = 80;
  localparam int        MARGIN      = 100;
  localparam csr_data_t START_PC    = 64'h0000_0000_8000_0000;

  logic        clk;
  logic        reset;
  logic        flush_i;
  logic        csr_wr_en_i;
  csr_addr_t   csr_wr_addr_i;
  csr_data_t   csr_wr_data_i;
  logic        commit_i;
  logic        rd_en_i;
  csr_addr_t   rd_addr_i;
  retire_cnt_t retire_count_i;
  trap_req_t   trap_i;
  csr_data_t   start_pc_i;
  csr_data_t   rd_data_o;
  logic        atomic_vio_o;
  csr_data_t   epc_o;
  csr_data_t   evec_o;
  priv_t       priv_o;

  // reference copies of the vector and epc registers
  csr_data_t   mtvec_m;
  csr_data_t   stvec_m;
  csr_data_t   mepc_m;

  csr_unit_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * (TEST_COUNT * TEST_CYCLES + MARGIN));
    $display("watchdog expired before the tests completed");
    $display("test failed");
    $fatal(1, "timeout");
  end

  function automatic csr_data_t rand64();
    return {$urandom, $urandom};
  endfunction

  // mstatus value built from its fields
  function automatic csr_data_t status_word(input logic [1:0] mpp, input logic spp,
      input logic mpie, input logic spie, input logic mie, input logic sie);
    return (csr_data_t'(mpp) << 11) | (csr_data_t'(spp) << 8) | (csr_data_t'(mpie) << 7)
           | (csr_data_t'(spie) << 5) | (csr_data_t'(mie) << 3) | (csr_data_t'(sie) << 1);
  endfunction

  function automatic trap_req_t trap_req(input logic exc, input logic mret, input logic sret,
      input cause_t cause, input csr_data_t pc);
    return '{exception: exc, mret: mret, sret: sret, cause: cause, pc: pc};
  endfunction

  task automatic check(input string name, input csr_data_t exp, input csr_data_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // one cycle of write enable, no commit
  task automatic capture_write(input csr_addr_t addr, input csr_data_t data);
    @(posedge clk);
    csr_wr_en_i   <= 1'b1;
    csr_wr_addr_i <= addr;
    csr_wr_data_i <= data;
    @(posedge clk);
    csr_wr_en_i <= 1'b0;
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
    capture_write(addr, data);
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
  endtask

  // point the read port at a CSR and wait for the combinational result
  task automatic select_read(input csr_addr_t addr);
    @(posedge clk);
    rd_addr_i <= addr;
    @(negedge clk);
  endtask

  task automatic read_expect(input string name, input csr_addr_t addr, input csr_data_t exp);
    select_read(addr);
    check(name, exp, rd_data_o);
  endtask

  // hold a trap request for one cycle, vector and epc checked while it is active
  task automatic request_trap(input string name, input trap_req_t req,
                              input csr_data_t exp_vec, input csr_data_t exp_epc);
    @(posedge clk);
    trap_i <= req;
    @(negedge clk);
    check({name, " evec"}, exp_vec, evec_o);
    check({name, " epc"}, exp_epc, epc_o);
    @(posedge clk);
    trap_i <= '0;
    @(negedge clk);
  endtask

  task automatic test_reset();
    check("reset priv", 64'd3, csr_data_t'(priv_o));
    check("reset vio", 64'd0, csr_data_t'(atomic_vio_o));
    read_expect("reset mtvec", CSR_MTVEC, START_PC);
    read_expect("reset mstatus", CSR_MSTATUS, 64'd0);
    read_expect("reset mscratch", CSR_MSCRATCH, 64'd0);
  endtask

  task automatic test_buffered_write();
    csr_data_t d0;
    csr_data_t d1;
    d0 = rand64();
    d1 = rand64();
    select_read(CSR_MSCRATCH);
    capture_write(CSR_MSCRATCH, d0);
    @(negedge clk);
    check("mscratch before commit", 64'd0, rd_data_o);
    @(posedge clk);
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
    @(negedge clk);
    check("mscratch after commit", d0, rd_data_o);
    // flushed write must stay dropped when a commit follows
    capture_write(CSR_MSCRATCH, d1);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i  <= 1'b0;
    commit_i <= 1'b1;
    @(posedge clk);
    commit_i <= 1'b0;
    read_expect("mscratch after flush", CSR_MSCRATCH, d0);
    write_csr(CSR_MTVEC, d1);
    mtvec_m = d1 & ~64'h2;
    read_expect("mtvec low bits", CSR_MTVEC, mtvec_m);
    write_csr(CSR_MEPC, d0);
    mepc_m = d0 & ~64'h1;
    read_expect("mepc low bit", CSR_MEPC, mepc_m);
    // machine fields mixed so any leak of the sstatus write shows up
    write_csr(CSR_MSTATUS, status_word(2'b11, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    write_csr(CSR_SSTATUS, '1);
    read_expect("sstatus write", CSR_MSTATUS, status_word(2'b11, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
    read_expect("sstatus read", CSR_SSTATUS, status_word(2'b00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1));
  endtask

  task automatic test_counters();
    csr_data_t   first;
    csr_data_t   sum;
    csr_data_t   start;
    retire_cnt_t r;
    int          i;
    select_read(CSR_MCYCLE);
    first = rd_data_o;
    repeat (10) @(negedge clk);
    check("mcycle distance", first + 64'd10, rd_data_o);
    select_read(CSR_MINSTRET);
    first = rd_data_o;
    sum = '0;
    for (i = 0; i < 8; i++) begin
      @(posedge clk);
      r = retire_cnt_t'($urandom % 5);
      retire_count_i <= r;
      sum = sum + csr_data_t'(r);
    end
    @(posedge clk);
    retire_count_i <= '0;
    @(negedge clk);
    check("minstret sum", first + sum, rd_data_o);
    start = rand64();
    select_read(CSR_MCYCLE);
    write_csr(CSR_MCYCLE, start);
    @(negedge clk);
    check("mcycle restart", start, rd_data_o);
    repeat (3) @(negedge clk);
    check("mcycle after restart", start + 64'd3, rd_data_o);
  endtask

  task automatic test_machine_trap();
    cause_t    cause;
    csr_data_t pc;
    cause = cause_t'($urandom);
    pc = rand64();
    write_csr(CSR_MSTATUS, status_word(2'b00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    request_trap("m trap", trap_req(1'b1, 1'b0, 1'b0, cause, pc), mtvec_m & ~64'h3, mepc_m);
    mepc_m = pc & ~64'h1;
    check("m trap priv", 64'd3, csr_data_t'(priv_o));
    read_expect("m trap mepc", CSR_MEPC, mepc_m);
    read_expect("m trap mcause", CSR_MCAUSE, csr_data_t'(cause));
    read_expect("m trap mstatus", CSR_MSTATUS, status_word(2'b11, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    request_trap("mret", trap_req(1'b0, 1'b1, 1'b0, '0, '0), mtvec_m & ~64'h3, mepc_m);
    check("mret priv", 64'd3, csr_data_t'(priv_o));
    read_expect("mret mstatus", CSR_MSTATUS, status_word(2'b00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
  endtask

  task automatic test_delegation();
    cause_t    cause;
    csr_data_t pc;
    csr_data_t sepc_m;
    // cause 11 is never delegable, keep the delegated one below it
    cause = cause_t'($urandom % 11);
    pc = rand64();
    stvec_m = rand64();
    write_csr(CSR_MEDELEG, csr_data_t'(1) << cause);
    write_csr(CSR_STVEC, stvec_m);
    stvec_m = stvec_m & ~64'h2;
    write_csr(CSR_MSTATUS, status_word(2'b01, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    request_trap("mret to s", trap_req(1'b0, 1'b1, 1'b0, '0, '0), mtvec_m & ~64'h3, mepc_m);
    check("mret to s priv", 64'd1, csr_data_t'(priv_o));
    request_trap("s trap", trap_req(1'b1, 1'b0, 1'b0, cause, pc), stvec_m & ~64'h3, mepc_m);
    sepc_m = pc & ~64'h1;
    check("s trap priv", 64'd1, csr_data_t'(priv_o));
    read_expect("s trap sepc", CSR_SEPC, sepc_m);
    read_expect("s trap scause", CSR_SCAUSE, csr_data_t'(cause));
    read_expect("s trap mstatus", CSR_MSTATUS, status_word(2'b00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
    request_trap("sret", trap_req(1'b0, 1'b0, 1'b1, '0, '0), mtvec_m & ~64'h3, sepc_m);
    check("sret priv", 64'd1, csr_data_t'(priv_o));
    read_expect("sret mstatus", CSR_MSTATUS, status_word(2'b00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
    pc = rand64();
    request_trap("undelegated", trap_req(1'b1, 1'b0, 1'b0, cause_t'(cause + 1), pc),
                 mtvec_m & ~64'h3, mepc_m);
    mepc_m = pc & ~64'h1;
    check("undelegated priv", 64'd3, csr_data_t'(priv_o));
    read_expect("undelegated mcause", CSR_MCAUSE, csr_data_t'(cause + 1));
    read_expect("undelegated mepc", CSR_MEPC, mepc_m);
    read_expect("undelegated mstatus", CSR_MSTATUS,
                status_word(2'b01, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
  endtask

  // mcycle moves every cycle, so its checkpoint goes stale at once
  task automatic stale_read_cleared(input string name, input logic use_flush);
    @(posedge clk);
    rd_en_i   <= 1'b1;
    rd_addr_i <= CSR_MCYCLE;
    @(posedge clk);
    rd_en_i <= 1'b0;
    @(negedge clk);
    check({name, " vio raised"}, 64'd1, csr_data_t'(atomic_vio_o));
    @(posedge clk);
    flush_i  <= use_flush;
    commit_i <= !use_flush;
    @(posedge clk);
    flush_i  <= 1'b0;
    commit_i <= 1'b0;
    @(negedge clk);
    check({name, " vio cleared"}, 64'd0, csr_data_t'(atomic_vio_o));
  endtask

  task automatic test_atomic_read();
    @(posedge clk);
    rd_en_i   <= 1'b1;
    rd_addr_i <= CSR_MSCRATCH;
    @(posedge clk);
    rd_en_i <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check("mscratch vio", 64'd0, csr_data_t'(atomic_vio_o));
    end
    stale_read_cleared("flush", 1'b1);
    stale_read_cleared("commit", 1'b0);
  endtask

  initial begin
    void'($urandom(32'h5784393d));
    reset          = 1'b1;
    flush_i        = 1'b0;
    csr_wr_en_i    = 1'b0;
    csr_wr_addr_i  = '0;
    csr_wr_data_i  = '0;
    commit_i       = 1'b0;
    rd_en_i        = 1'b0;
    rd_addr_i      = '0;
    retire_count_i = '0;
    trap_i         = '0;
    start_pc_i     = START_PC;
    mtvec_m        = START_PC;
    stvec_m        = '0;
    mepc_m         = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset();
    test_buffered_write();
    test_counters();
    test_machine_trap();
    test_delegation();
    test_atomic_read();
    $display("test passed");
    $finish;
  end

endmodule

//--- tests/csr_unit_asserts.sv
// concurrent checks on the CSR unit top level, bound into every instance of csr_unit_top
`timescale 1ns/100ps

module csr_unit_asserts (
  input logic                 clk,
  input logic                 reset,
  input logic                 flush_i,
  input logic                 rd_en_i,
  input csr_pkg::trap_req_t   trap_i,
  input csr_pkg::csr_data_t   epc_o,
  input csr_pkg::csr_data_t   evec_o,
  input csr_pkg::priv_t       priv_o,
  input logic                 atomic_vio_o
);
  import csr_pkg::*;

  // return pc and vector base stay aligned
  a_pc_align: assert property (@(posedge clk) disable iff (reset)
    (epc_o[0] == 1'b0) && (evec_o[1:0] == 2'b00))
    else $error("epc_o or evec_o carries set low bits");

  // a trap taken in machine mode cannot be delegated and stays in machine mode
  a_machine_trap: assert property (@(posedge clk) disable iff (reset)
    (trap_i.exception && (priv_o == PRIV_MACHINE)) |=> (priv_o == PRIV_MACHINE))
    else $error("machine-mode trap left machine mode");

  // flush drops the read checkpoint unless a new read arrives with it
  a_flush_clears: assert property (@(posedge clk) disable iff (reset)
    (flush_i && !rd_en_i) |=> !atomic_vio_o)
    else $error("atomic_vio_o high in the cycle after a flush");

endmodule

bind csr_unit_top csr_unit_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .flush_i      (flush_i),
  .rd_en_i      (rd_en_i),
  .trap_i       (trap_i),
  .epc_o        (epc_o),
  .evec_o       (evec_o),
  .priv_o       (priv_o),
  .atomic_vio_o (atomic_vio_o)
);

//--- hdl/csr_unit_top.sv
// CSR unit top level, connects the commit buffer, counters, trap state and read port
`timescale 1ns/100ps

module csr_unit_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush_i,
  input  logic                  csr_wr_en_i,
  input  csr_pkg::csr_addr_t    csr_wr_addr_i,
  input  csr_pkg::csr_data_t    csr_wr_data_i,
  input  logic                  commit_i,
  input  logic                  rd_en_i,
  input  csr_pkg::csr_addr_t    rd_addr_i,
  input  csr_pkg::retire_cnt_t  retire_count_i,
  input  csr_pkg::trap_req_t    trap_i,
  input  csr_pkg::csr_data_t    start_pc_i,
  output csr_pkg::csr_data_t    rd_data_o,
  output logic                  atomic_vio_o,
  output csr_pkg::csr_data_t    epc_o,
  output csr_pkg::csr_data_t    evec_o,
  output csr_pkg::priv_t        priv_o
);
  import csr_pkg::*;

  csr_write_t commit_wr;
  csr_state_t state;
  csr_data_t  mcycle;
  csr_data_t  minstret;

  csr_commit_buffer u_commit_buffer (
    .clk         (clk),
    .reset       (reset),
    .flush_i     (flush_i),
    .wr_en_i     (csr_wr_en_i),
    .wr_addr_i   (csr_wr_addr_i),
    .wr_data_i   (csr_wr_data_i),
    .commit_i    (commit_i),
    .commit_wr_o (commit_wr)
  );

  csr_counters u_counters (
    .clk            (clk),
    .reset          (reset),
    .commit_wr_i    (commit_wr),
    .retire_count_i (retire_count_i),
    .mcycle_o       (mcycle),
    .minstret_o     (minstret)
  );

  csr_trap_state u_trap_state (
    .clk         (clk),
    .reset       (reset),
    .commit_wr_i (commit_wr),
    .trap_i      (trap_i),
    .start_pc_i  (start_pc_i),
    .state_o     (state),
    .priv_o      (priv_o),
    .epc_o       (epc_o),
    .evec_o      (evec_o)
  );

  csr_read_port u_read_port (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .state_i      (state),
    .mcycle_i     (mcycle),
    .minstret_i   (minstret),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

endmodule

//--- hdl/csr_read_port.sv
// combinational CSR read mux plus the checkpoint that flags a read gone stale before commit
`timescale 1ns/100ps

module csr_read_port (
  input  logic                clk,
  input  logic                reset,
  input  logic                flush_i,
  input  logic                commit_i,
  input  logic                rd_en_i,
  input  csr_pkg::csr_addr_t  rd_addr_i,
  input  csr_pkg::csr_state_t state_i,
  input  csr_pkg::csr_data_t  mcycle_i,
  input  csr_pkg::csr_data_t  minstret_i,
  output csr_pkg::csr_data_t  rd_data_o,
  output logic                atomic_vio_o
);
  import csr_pkg::*;

  csr_addr_t chk_addr_q;
  csr_data_t chk_data_q;
  logic      chk_valid_q;
  csr_data_t chk_now;

  // shared decode for the live read and the checkpoint re-read
  function automatic csr_data_t read_csr(input csr_addr_t addr);
    csr_data_t val;
    case (addr)
      CSR_SSTATUS:  val = csr_data_t'(state_i.mstatus) & SSTATUS_MASK;
      CSR_STVEC:    val = state_i.stvec;
      CSR_SSCRATCH: val = state_i.sscratch;
      CSR_SEPC:     val = state_i.sepc;
      CSR_SCAUSE:   val = state_i.scause;
      CSR_MSTATUS:  val = csr_data_t'(state_i.mstatus);
      CSR_MEDELEG:  val = state_i.medeleg;
      CSR_MTVEC:    val = state_i.mtvec;
      CSR_MSCRATCH: val = state_i.mscratch;
      CSR_MEPC:     val = state_i.mepc;
      CSR_MCAUSE:   val = state_i.mcause;
      CSR_MCYCLE:   val = mcycle_i;
      CSR_MINSTRET: val = minstret_i;
      // user-level aliases
      CSR_CYCLE:    val = mcycle_i;
      CSR_INSTRET:  val = minstret_i;
      // unknown CSRs read zero, so they can never go stale
      default:      val = '0;
    endcase
    return val;
  endfunction

  assign rd_data_o = read_csr(rd_addr_i);
  assign chk_now   = read_csr(chk_addr_q);

  // address and data are only meaningful while chk_valid_q is set
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_o;
    end
  end

  // a new read keeps the checkpoint alive across flush or commit
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid_q <= 1'b1;
    end else if (flush_i || commit_i) begin
      chk_valid_q <= 1'b0;
    end
  end

  // the CSR changed between the read and commit of its instruction
  assign atomic_vio_o = chk_valid_q && (chk_now != chk_data_q);

endmodule

//--- hdl/csr_trap_state.sv
// privilege level, status and trap CSRs, with trap entry, mret/sret and committed writes
`timescale 1ns/100ps

module csr_trap_state (
  input  logic                clk,
  input  logic                reset,
  input  csr_pkg::csr_write_t commit_wr_i,
  input  csr_pkg::trap_req_t  trap_i,
  input  csr_pkg::csr_data_t  start_pc_i,
  output csr_pkg::csr_state_t state_o,
  output csr_pkg::priv_t      priv_o,
  output csr_pkg::csr_data_t  epc_o,
  output csr_pkg::csr_data_t  evec_o
);
  import csr_pkg::*;

  csr_state_t state_q;
  csr_state_t state_d;
  priv_t      priv_q;
  priv_t      priv_d;
  logic       to_super;

  // machine mode never delegates down, otherwise medeleg bit of the cause decides
  assign to_super = trap_i.exception && (priv_q != PRIV_MACHINE)
                    && state_q.medeleg[trap_i.cause];

  always_comb begin
    state_d = state_q;
    priv_d  = priv_q;

    if (trap_i.exception) begin
      if (to_super) begin
        state_d.mstatus.spie = state_q.mstatus.sie;
        state_d.mstatus.sie  = 1'b0;
        state_d.mstatus.spp  = priv_q[0];
        state_d.scause       = csr_data_t'(trap_i.cause);
        // pc is halfword aligned at least
        state_d.sepc         = {trap_i.pc[CSR_DATA_W-1:1], 1'b0};
        priv_d               = PRIV_SUPERVISOR;
      end else begin
        state_d.mstatus.mpie = state_q.mstatus.mie;
        state_d.mstatus.mie  = 1'b0;
        state_d.mstatus.mpp  = priv_q;
        state_d.mcause       = csr_data_t'(trap_i.cause);
        state_d.mepc         = {trap_i.pc[CSR_DATA_W-1:1], 1'b0};
        priv_d               = PRIV_MACHINE;
      end
    end else if (trap_i.mret) begin
      state_d.mstatus.mie  = state_q.mstatus.mpie;
      state_d.mstatus.mpie = 1'b1;
      state_d.mstatus.mpp  = PRIV_USER;
      priv_d               = priv_t'(state_q.mstatus.mpp);
    end else if (trap_i.sret) begin
      state_d.mstatus.sie  = state_q.mstatus.spie;
      state_d.mstatus.spie = 1'b1;
      state_d.mstatus.spp  = 1'b0;
      // spp only encodes user or supervisor
      priv_d               = state_q.mstatus.spp ? PRIV_SUPERVISOR : PRIV_USER;
    end

    // committed write is applied last so it overrides a trap update
    if (commit_wr_i.en) begin
      case (commit_wr_i.addr)
        CSR_MSTATUS: begin
          state_d.mstatus = status_t'(commit_wr_i.data & MSTATUS_MASK);
        end
        CSR_SSTATUS: begin
          // machine fields keep their value
          state_d.mstatus = status_t'((commit_wr_i.data & SSTATUS_MASK)
                                      | (csr_data_t'(state_d.mstatus) & ~SSTATUS_MASK));
        end
        CSR_MEDELEG: begin
          state_d.medeleg = commit_wr_i.data & MEDELEG_MASK;
        end
        CSR_MTVEC: begin
          state_d.mtvec = {commit_wr_i.data[CSR_DATA_W-1:2], 1'b0, commit_wr_i.data[0]};
        end
        CSR_STVEC: begin
          state_d.stvec = {commit_wr_i.data[CSR_DATA_W-1:2], 1'b0, commit_wr_i.data[0]};
        end
        CSR_MEPC: begin
          state_d.mepc = {commit_wr_i.data[CSR_DATA_W-1:1], 1'b0};
        end
        CSR_SEPC: begin
          state_d.sepc = {commit_wr_i.data[CSR_DATA_W-1:1], 1'b0};
        end
        CSR_MCAUSE:   state_d.mcause   = commit_wr_i.data;
        CSR_SCAUSE:   state_d.scause   = commit_wr_i.data;
        CSR_MSCRATCH: state_d.mscratch = commit_wr_i.data;
        CSR_SSCRATCH: state_d.sscratch = commit_wr_i.data;
        default: begin
          // counters and unknown addresses are not held here
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q       <= '0;
      state_q.mtvec <= start_pc_i;
      priv_q        <= PRIV_MACHINE;
    end else begin
      state_q <= state_d;
      priv_q  <= priv_d;
    end
  end

  assign state_o = state_q;
  assign priv_o  = priv_q;

  // recovery pc for the return in flight
  assign epc_o = trap_i.sret ? state_q.sepc : state_q.mepc;

  // vector base only, mode bits dropped
  assign evec_o = to_super ? {state_q.stvec[CSR_DATA_W-1:2], 2'b00}
                           : {state_q.mtvec[CSR_DATA_W-1:2], 2'b00};

endmodule

//--- hdl/csr_counters.sv
// cycle and retired-instruction counters, software can overwrite either on a committed write
`timescale 1ns/100ps

module csr_counters (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_write_t  commit_wr_i,
  input  csr_pkg::retire_cnt_t retire_count_i,
  output csr_pkg::csr_data_t   mcycle_o,
  output csr_pkg::csr_data_t   minstret_o
);
  import csr_pkg::*;

  csr_data_t mcycle_q;
  csr_data_t minstret_q;
  logic      wr_mcycle;
  logic      wr_minstret;

  assign wr_mcycle   = commit_wr_i.en && (commit_wr_i.addr == CSR_MCYCLE);
  assign wr_minstret = commit_wr_i.en && (commit_wr_i.addr == CSR_MINSTRET);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      // written value replaces this cycle's increment
      if (wr_mcycle) begin
        mcycle_q <= commit_wr_i.data;
      end else begin
        mcycle_q <= mcycle_q + csr_data_t'(1);
      end

      // up to four instructions retire per cycle
      if (wr_minstret) begin
        minstret_q <= commit_wr_i.data;
      end else begin
        minstret_q <= minstret_q + csr_data_t'(retire_count_i);
      end
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

//--- hdl/csr_commit_buffer.sv
// single-entry buffer that holds a speculative CSR write until its instruction commits
`timescale 1ns/100ps

module csr_commit_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                flush_i,
  input  logic                wr_en_i,
  input  csr_pkg::csr_addr_t  wr_addr_i,
  input  csr_pkg::csr_data_t  wr_data_i,
  input  logic                commit_i,
  output csr_pkg::csr_write_t commit_wr_o
);
  import csr_pkg::*;

  csr_addr_t addr_q;
  csr_data_t data_q;
  logic      pending_q;

  // payload only, qualified by pending_q
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      addr_q <= wr_addr_i;
      data_q <= wr_data_i;
    end
  end

  // a new capture wins over flush or commit in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (wr_en_i) begin
      pending_q <= 1'b1;
    end else if (flush_i || commit_i) begin
      pending_q <= 1'b0;
    end
  end

  assign commit_wr_o = '{en: commit_i && pending_q, addr: addr_q, data: data_q};

endmodule

//--- hdl/csr_pkg.sv
// shared CSR widths, addresses, write masks and bus structs, imported by every CSR unit module
package csr_pkg;

  // fixed ISA widths
  localparam int CSR_ADDR_W   = 12;
  localparam int CSR_DATA_W   = 64;
  localparam int RETIRE_CNT_W = 3;
  localparam int CAUSE_W      = 4;

  typedef logic [CSR_ADDR_W-1:0]   csr_addr_t;
  typedef logic [CSR_DATA_W-1:0]   csr_data_t;
  typedef logic [RETIRE_CNT_W-1:0] retire_cnt_t;
  typedef logic [CAUSE_W-1:0]      cause_t;

  typedef enum logic [1:0] {
    PRIV_USER       = 2'd0,
    PRIV_SUPERVISOR = 2'd1,
    PRIV_MACHINE    = 2'd3
  } priv_t;

  // supervisor CSRs
  localparam csr_addr_t CSR_SSTATUS  = 12'h100;
  localparam csr_addr_t CSR_STVEC    = 12'h105;
  localparam csr_addr_t CSR_SSCRATCH = 12'h140;
  localparam csr_addr_t CSR_SEPC     = 12'h141;
  localparam csr_addr_t CSR_SCAUSE   = 12'h142;

  // machine CSRs
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MEDELEG  = 12'h302;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  // counters and their user-level aliases
  localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;
  localparam csr_addr_t CSR_CYCLE    = 12'hC00;
  localparam csr_addr_t CSR_INSTRET  = 12'hC02;

  // mpp, spp, mpie, spie, mie, sie
  localparam csr_data_t MSTATUS_MASK = 64'h0000_0000_0000_19AA;
  // spp, spie, sie
  localparam csr_data_t SSTATUS_MASK = 64'h0000_0000_0000_0122;
  // causes 0..15 except ecall from M-mode
  localparam csr_data_t MEDELEG_MASK = 64'h0000_0000_0000_F7FF;

  // mstatus layout, reserved bits stay zero
  typedef struct packed {
    logic [50:0] rsv_63_13;
    logic [1:0]  mpp;
    logic [1:0]  rsv_10_9;
    logic        spp;
    logic        mpie;
    logic        rsv_6;
    logic        spie;
    logic        rsv_4;
    logic        mie;
    logic        rsv_2;
    logic        sie;
    logic        rsv_0;
  } status_t;

  // one write leaving the commit buffer
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_data_t data;
  } csr_write_t;

  // trap entry or return request from the retire stage
  typedef struct packed {
    logic      exception;
    logic      mret;
    logic      sret;
    cause_t    cause;
    csr_data_t pc;
  } trap_req_t;

  typedef struct packed {
    status_t   mstatus;
    csr_data_t medeleg;
    csr_data_t mtvec;
    csr_data_t stvec;
    csr_data_t mepc;
    csr_data_t sepc;
    csr_data_t mcause;
    csr_data_t scause;
    csr_data_t mscratch;
    csr_data_t sscratch;
  } csr_state_t;

endpackage
